//--- test/preif_stim.txt
# T id | M vpn pfn valid | R mask(exc eret refetch correct) exc eret refetch correct
# F flush | P random_ready | E pc instr except lookup | W wait for queued beats
T 1
E bfc00000 e03f0000 0 0
E bfc00004 e03f0004 0 0
E bfc00008 e03f0008 0 0
E bfc0000c e03f000c 0 0
W
T 2
R d bfc00380 80001000 0 80002000
E bfc00380 e03f0380 0 0
E bfc00384 e03f0384 0 0
W
R 4 0 80001000 0 0
E 80001000 ffff1000 0 0
W
R 1 0 0 0 a0000040
E a0000040 ffff0040 0 0
W
T 3
M 00400 00123 1
R 1 0 0 0 00400000
E 00400000 ffed3000 0 1
E 00400004 ffed3004 0 0
W
F
R 1 0 0 0 00400010
E 00400010 ffed3010 0 1
W
T 4
R 1 0 0 0 00500000
E 00500000 00000000 2 1
W
M 00600 00456 0
R 1 0 0 0 00600000
E 00600000 00000000 3 1
W
T 5
R 1 0 0 0 a0000102
E a0000102 00000000 1 0
W
T 6
P 1
R 1 0 0 0 bfc01000
E bfc01000 e03f1000 0 0
E bfc01004 e03f1004 0 0
E bfc01008 e03f1008 0 0
E bfc0100c e03f100c 0 0
E bfc01010 e03f1010 0 0
E bfc01014 e03f1014 0 0
W

//--- sources.f
design/fetch_pkg.sv
design/pc_gen.sv
design/itlb_buffer.sv
design/ifetch_wb.sv
design/preif_top.sv
test/preif_checker.sv
test/preif_tb.sv

//--- Makefile
TOP       ?= preif_tb
SEED      ?= 1744102640
TIMEOUT   ?= 0
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator

SRCS := $(shell grep -v '^+' sources.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sources.f
	$(VERILATOR) --binary --timing -Mdir $(BUILD) --top-module $(TOP) \
		-GSEED=$(SEED) -GTIMEOUT=$(TIMEOUT) -f sources.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/preif_tb.sv
`timescale 1ns/1ps

module preif_tb import fetch_pkg::*; #(
    parameter logic [31:0] SEED    = 32'h67f4_e4f0,
    parameter int          TIMEOUT = 0              // 0 means derived from the stim file
) ();
    localparam word_t MEM_KEY  = 32'hffff_0000;    // memory model data pattern
    localparam int    MAX_CMDS = 96;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    exc_valid = 1'b0, eret_valid = 1'b0, refetch_valid = 1'b0, correct_valid = 1'b0;
    addr_t   exc_vector = '0, epc = '0, refetch_pc = '0, correct_pc = '0;
    logic    tlb_flush = 1'b0;
    logic    tlb_found, tlb_valid;
    pfn_t    tlb_pfn;
    vpn_t    lookup_vpn;
    logic    tlb_stall;
    logic    wb_cyc, wb_stb, wb_ack = 1'b0;
    addr_t   wb_adr;
    word_t   wb_dat_i = '0;
    logic    if_ready = 1'b0;
    logic    fetch_valid;
    addr_t   fetch_pc;
    word_t   fetch_instr;
    except_t fetch_except;

    byte         ops [MAX_CMDS];
    logic [31:0] args[MAX_CMDS][5];
    int          n_cmds = 0;
    int          n_expect = 0;
    logic        loaded = 1'b0;
    logic        ready_random = 1'b0;
    int          cycles = 0;
    int          wait_left = 0;
    integer      seed = SEED;                       // bus wait states
    integer      ready_seed = SEED ^ 32'h0000_0001; // if_ready pattern

    // main TLB model
    vpn_t tab_vpn [8];
    pfn_t tab_pfn [8];
    logic tab_v   [8];
    logic tab_used[8] = '{default: 1'b0};
    int   n_tab = 0;

    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    preif_top #(.RESET_PC(RESET_VECTOR)) UUT (.*);

    preif_checker chk (.*);

    always @* begin
        tlb_found = 1'b0;
        tlb_pfn   = '0;
        tlb_valid = 1'b0;
        for (int k = 0; k < 8; k++) begin
            if (tab_used[k] && tab_vpn[k] == lookup_vpn) begin
                tlb_found = 1'b1;
                tlb_pfn   = tab_pfn[k];
                tlb_valid = tab_v[k];
            end
        end
    end

    // wishbone memory, 0 to 3 wait states per read
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 0) begin
                wb_ack    = 1'b1;
                wb_dat_i  = wb_adr ^ MEM_KEY;
                wait_left = $random(seed) & 3;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic load_stim(output logic ok);
        int    fd;
        int    code;
        string op;
        string rest;
        fd = $fopen("test/preif_stim.txt", "r");
        ok = fd != 0;
        if (ok) begin
            while ($fscanf(fd, "%s", op) == 1) begin
                code = 0;
                if (op == "#")
                    code = $fgets(rest, fd);    // comment line
                else begin
                    ops[n_cmds] = op.getc(0);
                    case (op)
                        "T", "P": code = $fscanf(fd, "%h", args[n_cmds][0]);
                        "M": code = $fscanf(fd, "%h %h %h", args[n_cmds][0],
                                            args[n_cmds][1], args[n_cmds][2]);
                        "R": code = $fscanf(fd, "%h %h %h %h %h", args[n_cmds][0],
                                            args[n_cmds][1], args[n_cmds][2],
                                            args[n_cmds][3], args[n_cmds][4]);
                        "E": begin
                            code = $fscanf(fd, "%h %h %h %h", args[n_cmds][0],
                                           args[n_cmds][1], args[n_cmds][2],
                                           args[n_cmds][3]);
                            n_expect++;
                        end
                        default: code = 0;
                    endcase
                    n_cmds++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_redirect(input logic [31:0] mask, input addr_t e, input addr_t er,
                                  input addr_t rf, input addr_t cr);
        @(posedge clk);
        #1;
        exc_valid     = mask[3];
        exc_vector    = e;
        eret_valid    = mask[2];
        epc           = er;
        refetch_valid = mask[1];
        refetch_pc    = rf;
        correct_valid = mask[0];
        correct_pc    = cr;
        @(posedge clk);
        #1;
        {exc_valid, eret_valid, refetch_valid, correct_valid} = 4'b0000;
    endtask

    task automatic pulse_flush;
        @(posedge clk);
        #1 tlb_flush = 1'b1;
        @(posedge clk);
        #1 tlb_flush = 1'b0;
    endtask

    // let IF take beats until every queued beat has been seen
    task automatic drain_beats;
        while (chk.seen < chk.pushed) begin
            @(posedge clk);
            #1;
            if (chk.seen >= chk.pushed)
                if_ready = 1'b0;
            else if (ready_random)
                if_ready = ($random(ready_seed) & 1) != 0;
            else
                if_ready = 1'b1;
        end
        if_ready = 1'b0;
    endtask

    task automatic run_cmds;
        logic test_open;
        test_open = 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            case (ops[i])
                "T": begin
                    if (test_open)
                        chk.end_test();
                    chk.start_test(int'(args[i][0]));
                    test_open = 1'b1;
                end
                "M": begin
                    tab_vpn[n_tab]  = args[i][0][19:0];
                    tab_pfn[n_tab]  = args[i][1][19:0];
                    tab_v[n_tab]    = args[i][2][0];
                    tab_used[n_tab] = 1'b1;
                    n_tab++;
                end
                "R": apply_redirect(args[i][0], args[i][1], args[i][2], args[i][3], args[i][4]);
                "F": pulse_flush();
                "P": ready_random = args[i][0][0];
                "E": chk.push_beat(args[i][0], args[i][1], args[i][2][1:0], args[i][3][0]);
                "W": drain_beats();
                default: $display("unknown stim command %c skipped", ops[i]);
            endcase
        end
        if (test_open)
            chk.end_test();
    endtask

    initial begin
        logic ok;
        load_stim(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("could not open test/preif_stim.txt");
            $display("Test failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #1 rst = 1'b0;
            run_cmds();
            $display("tests %0d, beats %0d of %0d, errors %0d",
                     chk.tests, chk.seen, chk.pushed, chk.errors);
            if (chk.errors == 0 && chk.seen == chk.pushed)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (TIMEOUT != 0) ? TIMEOUT : n_expect * 12 + 200;
        while (cycles < limit)
            @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

//--- test/preif_checker.sv
`timescale 1ns/1ps

module preif_checker import fetch_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    fetch_valid,
    input logic    if_ready,
    input addr_t   fetch_pc,
    input word_t   fetch_instr,
    input except_t fetch_except,
    input logic    wb_cyc,
    input logic    wb_stb,
    input logic    tlb_stall,
    input vpn_t    lookup_vpn
);
    addr_t   exp_pc[$];
    word_t   exp_instr[$];
    except_t exp_exc[$];
    logic    exp_lk[$];        // a main TLB lookup must precede this beat

    int pushed = 0, seen = 0, errors = 0, tests = 0, test_id = 0, test_errors = 0;

    logic  prev_cyc, prev_valid, prev_hold, bus_beat, stall_seen;
    addr_t prev_pc;
    vpn_t  stall_vpn;

    task automatic push_beat(input addr_t pc, input word_t instr, input except_t exc,
                             input logic lk);
        exp_pc.push_back(pc);
        exp_instr.push_back(instr);
        exp_exc.push_back(exc);
        exp_lk.push_back(lk);
        pushed++;
    endtask

    task automatic start_test(input int id);
        test_id     = id;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test;
        $display("test %0d done, %0d beats so far, %0d errors", test_id, seen, test_errors);
    endtask

    task automatic fail(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_beat(input logic via_bus, input logic looked_up);
        addr_t   pc;
        except_t exc;
        if (exp_pc.size() == 0) begin
            fail($sformatf("unexpected beat pc %h", fetch_pc));
        end else begin
            pc  = exp_pc.pop_front();
            exc = exp_exc.pop_front();
            if (fetch_pc != pc)
                fail($sformatf("beat pc %h, expected %h", fetch_pc, pc));
            if (fetch_instr != exp_instr[0])
                fail($sformatf("pc %h instr %h, expected %h", pc, fetch_instr, exp_instr[0]));
            if (fetch_except != exc)
                fail($sformatf("pc %h except %0d, expected %0d", pc, fetch_except, exc));
            if (via_bus != (exc == EXC_NONE))
                fail($sformatf("pc %h bus cycle %0d, expected %0d", pc, via_bus,
                               exc == EXC_NONE));
            if (looked_up != exp_lk[0])
                fail($sformatf("pc %h main TLB lookup %0d, expected %0d", pc, looked_up,
                               exp_lk[0]));
            else if (looked_up && stall_vpn != pc[31:12])
                fail($sformatf("lookup_vpn %h, expected %h", stall_vpn, pc[31:12]));
            void'(exp_instr.pop_front());
            void'(exp_lk.pop_front());
        end
        seen++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            prev_cyc   <= 1'b0;
            prev_valid <= 1'b0;
            prev_hold  <= 1'b0;
            bus_beat   <= 1'b0;
            stall_seen <= 1'b0;
        end else begin
            if (fetch_valid && !prev_valid)
                bus_beat <= prev_cyc;       // ack cycle right before the beat
            if (tlb_stall) begin
                stall_seen <= 1'b1;
                stall_vpn  <= lookup_vpn;
            end
            if (wb_stb != wb_cyc)
                fail($sformatf("wb_stb %0d differs from wb_cyc %0d", wb_stb, wb_cyc));
            if (fetch_valid && prev_hold && fetch_pc != prev_pc)
                fail($sformatf("fetch_pc moved from %h to %h while held", prev_pc, fetch_pc));
            if (fetch_valid && if_ready) begin
                check_beat(prev_valid ? bus_beat : prev_cyc, stall_seen);
                stall_seen <= 1'b0;
            end
            prev_cyc   <= wb_cyc;
            prev_valid <= fetch_valid;
            prev_hold  <= fetch_valid && !if_ready;
            prev_pc    <= fetch_pc;
        end
    end

endmodule

//--- design/preif_top.sv
`timescale 1ns/1ps

module preif_top import fetch_pkg::*; #(
    parameter addr_t RESET_PC = RESET_VECTOR
) (
    input  logic    clk,
    input  logic    rst,
    // redirect pulses
    input  logic    exc_valid,
    input  addr_t   exc_vector,
    input  logic    eret_valid,
    input  addr_t   epc,
    input  logic    refetch_valid,
    input  addr_t   refetch_pc,
    input  logic    correct_valid,
    input  addr_t   correct_pc,
    // main TLB
    input  logic    tlb_flush,
    input  logic    tlb_found,
    input  pfn_t    tlb_pfn,
    input  logic    tlb_valid,
    output vpn_t    lookup_vpn,
    output logic    tlb_stall,
    // wishbone, word reads only so no we or sel
    output logic    wb_cyc,
    output logic    wb_stb,
    output addr_t   wb_adr,
    input  word_t   wb_dat_i,
    input  logic    wb_ack,
    // toward IF
    input  logic    if_ready,
    output logic    fetch_valid,
    output addr_t   fetch_pc,
    output word_t   fetch_instr,
    output except_t fetch_except
);
    addr_t   pc;
    logic    advance;
    logic    redirect_pending;
    logic    tr_ready;
    addr_t   paddr;
    except_t tr_except;

    pc_gen #(
        .RESET_PC         (RESET_PC)
    ) u_pc_gen (
        .clk              (clk),
        .rst              (rst),
        .exc_valid        (exc_valid),
        .exc_vector       (exc_vector),
        .eret_valid       (eret_valid),
        .epc              (epc),
        .refetch_valid    (refetch_valid),
        .refetch_pc       (refetch_pc),
        .correct_valid    (correct_valid),
        .correct_pc       (correct_pc),
        .advance          (advance),
        .redirect_pending (redirect_pending),
        .pc               (pc)
    );

    itlb_buffer u_itlb (
        .clk              (clk),
        .rst              (rst),
        .pc               (pc),
        .tlb_flush        (tlb_flush),
        .tlb_found        (tlb_found),
        .tlb_pfn          (tlb_pfn),
        .tlb_valid        (tlb_valid),
        .lookup_vpn       (lookup_vpn),
        .tlb_stall        (tlb_stall),
        .tr_ready         (tr_ready),
        .paddr            (paddr),
        .tr_except        (tr_except)
    );

    ifetch_wb u_fetch (
        .clk              (clk),
        .rst              (rst),
        .tr_ready         (tr_ready),
        .paddr            (paddr),
        .tr_except        (tr_except),
        .pc               (pc),
        .redirect_pending (redirect_pending),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_adr           (wb_adr),
        .wb_dat_i         (wb_dat_i),
        .wb_ack           (wb_ack),
        .if_ready         (if_ready),
        .advance          (advance),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_instr      (fetch_instr),
        .fetch_except     (fetch_except)
    );

endmodule

//--- design/ifetch_wb.sv
`timescale 1ns/1ps

module ifetch_wb import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    tr_ready,
    input  addr_t   paddr,
    input  except_t tr_except,
    input  addr_t   pc,
    input  logic    redirect_pending,
    output logic    wb_cyc,
    output logic    wb_stb,
    output addr_t   wb_adr,
    input  word_t   wb_dat_i,
    input  logic    wb_ack,
    input  logic    if_ready,
    output logic    advance,
    output logic    fetch_valid,
    output addr_t   fetch_pc,
    output word_t   fetch_instr,
    output except_t fetch_except
);
    fetch_state_t state;
    fetch_state_t state_next;
    logic         launch;       // take the translated pc this cycle

    assign launch = (state == ST_IDLE) && tr_ready && !redirect_pending;

    always_comb begin
        state_next = state;
        advance    = 1'b0;
        case (state)
            ST_IDLE: begin
                if (redirect_pending)
                    advance = 1'b1;     // old pc dropped before any fetch
                else if (tr_ready)
                    state_next = (tr_except == EXC_NONE) ? ST_BUS : ST_HOLD;
            end
            ST_BUS: begin
                // classic bus cannot abort, so wait for ack either way
                if (wb_ack) begin
                    if (redirect_pending) begin
                        advance    = 1'b1;
                        state_next = ST_IDLE;
                    end else begin
                        state_next = ST_HOLD;
                    end
                end
            end
            ST_HOLD: begin
                if (redirect_pending || if_ready) begin
                    advance    = 1'b1;  // accepted or discarded
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fetch_pc     <= pc;
            fetch_except <= tr_except;
            fetch_instr  <= '0;         // stays zero on exception beats
            wb_adr       <= paddr;
        end
        if (state == ST_BUS && wb_ack)
            fetch_instr <= wb_dat_i;
    end

    assign wb_cyc = state == ST_BUS;
    assign wb_stb = state == ST_BUS;

    // a pending redirect hides the held beat until it is dropped
    assign fetch_valid = (state == ST_HOLD) && !redirect_pending;

endmodule

//--- design/itlb_buffer.sv
`timescale 1ns/1ps

module itlb_buffer import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   pc,
    input  logic    tlb_flush,
    input  logic    tlb_found,
    input  pfn_t    tlb_pfn,
    input  logic    tlb_valid,
    output vpn_t    lookup_vpn,
    output logic    tlb_stall,
    output logic    tr_ready,
    output addr_t   paddr,
    output except_t tr_except
);
    vpn_t pc_vpn;
    logic misaligned;
    logic unmapped;

    // the single buffered entry
    logic ent_used;
    vpn_t ent_vpn;
    pfn_t ent_pfn;
    logic ent_v;
    logic ent_hit;

    // main TLB missed on this page, entry itself is not kept
    logic refill_q;
    vpn_t refill_vpn;
    logic refill_hit;

    assign pc_vpn     = pc[31:12];
    assign lookup_vpn = pc_vpn;

    assign misaligned = pc[1:0] != 2'b00;
    assign unmapped   = (pc[31:29] == SEG_KSEG0) || (pc[31:29] == SEG_KSEG1);

    assign ent_hit    = ent_used && (ent_vpn == pc_vpn);
    assign refill_hit = refill_q && (refill_vpn == pc_vpn);

    // ask the main TLB only for an aligned mapped pc with nothing buffered
    assign tlb_stall  = !misaligned && !unmapped && !ent_hit && !refill_hit;

    always_comb begin
        tr_ready  = 1'b1;
        paddr     = pc & KSEG_MASK;
        tr_except = EXC_NONE;
        if (misaligned) begin
            tr_except = EXC_ADDR_ERR;   // no lookup at all
        end else if (!unmapped) begin
            if (ent_hit) begin
                paddr = {ent_pfn, pc[11:0]};
                if (!ent_v)
                    tr_except = EXC_TLB_INVALID;
            end else if (refill_hit) begin
                tr_except = EXC_TLB_REFILL;
            end else begin
                tr_ready = 1'b0;        // stall cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_used <= 1'b0;
            refill_q <= 1'b0;
        end else if (tlb_flush) begin
            ent_used <= 1'b0;
            refill_q <= 1'b0;
        end else if (tlb_stall) begin
            if (tlb_found)
                ent_used <= 1'b1;
            refill_q <= !tlb_found;
        end else if (refill_q && !refill_hit) begin
            refill_q <= 1'b0;           // pc left the missing page
        end
    end

    // answer captured at the end of the stall cycle
    always_ff @(posedge clk) begin
        if (tlb_stall) begin
            refill_vpn <= pc_vpn;
            if (tlb_found) begin
                ent_vpn <= pc_vpn;
                ent_pfn <= tlb_pfn;
                ent_v   <= tlb_valid;
            end
        end
    end

endmodule

//--- design/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter addr_t RESET_PC = RESET_VECTOR
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  exc_valid,
    input  addr_t exc_vector,
    input  logic  eret_valid,
    input  addr_t epc,
    input  logic  refetch_valid,
    input  addr_t refetch_pc,
    input  logic  correct_valid,
    input  addr_t correct_pc,
    input  logic  advance,
    output logic  redirect_pending,
    output addr_t pc
);
    logic       req_valid;
    logic [1:0] req_pri;        // 3 = exception ... 0 = correction
    addr_t      req_target;
    logic       req_wins;

    logic       pend_valid;
    logic [1:0] pend_pri;
    addr_t      pend_target;

    addr_t      pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // fixed priority among this cycle's redirect pulses
    always_comb begin
        req_valid  = 1'b1;
        req_pri    = 2'd0;
        req_target = correct_pc;
        if (exc_valid) begin
            req_pri    = 2'd3;
            req_target = exc_vector;
        end else if (eret_valid) begin
            req_pri    = 2'd2;
            req_target = epc;
        end else if (refetch_valid) begin
            req_pri    = 2'd1;
            req_target = refetch_pc;
        end else if (!correct_valid) begin
            req_valid  = 1'b0;
        end
    end

    // equal priority also replaces, the newer one is the right target
    assign req_wins = req_valid && (!pend_valid || req_pri >= pend_pri);

    assign redirect_pending = pend_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            pend_valid <= 1'b0;
        end else if (advance) begin
            if (req_wins)
                pc <= req_target;      // redirect arriving with the advance
            else if (pend_valid)
                pc <= pend_target;
            else
                pc <= pc_plus4;
            pend_valid <= 1'b0;
        end else if (req_wins) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_wins) begin
            pend_pri    <= req_pri;
            pend_target <= req_target;
        end
    end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;    // virtual or physical
    typedef logic [31:0] word_t;
    typedef logic [19:0] vpn_t;     // 4 KB pages
    typedef logic [19:0] pfn_t;
    typedef logic [1:0]  except_t;

    // fetch exception codes
    localparam except_t EXC_NONE        = 2'd0;
    localparam except_t EXC_ADDR_ERR    = 2'd1;
    localparam except_t EXC_TLB_REFILL  = 2'd2;
    localparam except_t EXC_TLB_INVALID = 2'd3;

    // top three address bits of the unmapped kernel segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    localparam addr_t KSEG_MASK    = 32'h1fff_ffff;  // clears bits 31..29
    localparam addr_t RESET_VECTOR = 32'hbfc0_0000;  // boot rom in kseg1

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for a translated pc
        ST_BUS,     // wishbone read open
        ST_HOLD     // beat waiting for IF
    } fetch_state_t;

endpackage
